/* filelist.f */
+incdir+src
src/edge_mem_pkg.sv
src/edge_job_pkg.sv
src/edge_read_sequencer.sv
src/edge_line_unpacker.sv
src/edge_job_fifo.sv
src/cu_edge_job_control.sv
verification/edge_job_asserts.sv
verification/edge_job_checker.sv
verification/tb_edge_job.sv

/* Makefile */
# Verilator build and run of the edge job testbench

VERILATOR ?= verilator
TOP       ?= tb_edge_job
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_edge_job.sv */
`include "edge_job_defines.svh"

module tb_edge_job
	import edge_job_pkg::*, edge_mem_pkg::*;
();

	localparam int NUM_VERTICES = 40;
	localparam int MAX_DEGREE   = 100;
	localparam int MAX_FIRST    = 200;
	// four cycles an edge and twenty a line over four lines a vertex
	localparam int TIMEOUT_CYCLES = NUM_VERTICES * (MAX_DEGREE * 4 + 4 * 20);

	logic                  clock;
	logic                  rstn;
	logic                  vertex_valid;
	vertex_job_t           vertex_job;
	logic [`ADDR_BITS-1:0] edge_base;
	logic                  read_data_valid;
	mem_line_u             read_data;
	logic                  edge_request;
	logic                  vertex_ready;
	logic                  read_valid;
	logic [`ADDR_BITS-1:0] read_addr;
	read_len_t             read_len;
	logic                  edge_valid;
	edge_job_t             edge_job;
	logic                  edge_available;

	int          value_errors;
	int          other_errors;
	int          pending;
	int          cycle_count = 0;
	logic [31:0] rng_state;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// memory contents fixed by line address and slot
	function automatic logic [31:0] slot_value(input logic [`ADDR_BITS-1:0] addr, input int slot);
		logic [31:0] mixed;
		mixed = addr ^ (32'(slot) << 24) ^ 32'h5bd1e995;
		return mixed * 32'd1664525 + 32'd1013904223;
	endfunction

	initial clock = 1'b0;
	always #4 clock = ~clock;

	cu_edge_job_control UUT (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_valid   (vertex_valid),
		.vertex_job     (vertex_job),
		.edge_base      (edge_base),
		.read_data_valid(read_data_valid),
		.read_data      (read_data),
		.edge_request   (edge_request),
		.vertex_ready   (vertex_ready),
		.read_valid     (read_valid),
		.read_addr      (read_addr),
		.read_len       (read_len),
		.edge_valid     (edge_valid),
		.edge_job       (edge_job),
		.edge_available (edge_available)
	);

	edge_job_checker u_checker (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_valid   (vertex_valid),
		.vertex_job     (vertex_job),
		.vertex_ready   (vertex_ready),
		.edge_base      (edge_base),
		.read_valid     (read_valid),
		.read_addr      (read_addr),
		.read_len       (read_len),
		.read_data_valid(read_data_valid),
		.read_data      (read_data),
		.edge_request   (edge_request),
		.edge_valid     (edge_valid),
		.edge_job       (edge_job),
		.edge_available (edge_available),
		.value_errors   (value_errors),
		.other_errors   (other_errors),
		.pending        (pending)
	);

	bind cu_edge_job_control edge_job_asserts u_asserts (
		.clock          (clock),
		.rstn           (rstn),
		.read_valid     (read_valid),
		.read_data_valid(read_data_valid),
		.read_addr      (read_addr),
		.read_len       (read_len),
		.push           (push),
		.edge_request   (edge_request),
		.edge_available (edge_available)
	);

	//////////////////////////////
	// reset and vertex stimulus
	//////////////////////////////

	initial begin
		int gap;
		int first;
		int degree;
		rng_state       = 32'h0aa79834;
		rstn            = 1'b0;
		vertex_valid    = 1'b0;
		vertex_job      = '0;
		edge_base       = '0;
		read_data_valid = 1'b0;
		read_data       = '0;
		edge_request    = 1'b0;
		repeat (10) @(posedge clock);
		rstn      <= 1'b1;
		edge_base <= lcg_next() & ~32'(`LINE_BYTES - 1);
		for (int i = 0; i < NUM_VERTICES; i++) begin
			gap = int'(lcg_next() >> 29);
			repeat (gap) @(posedge clock);
			first = int'(lcg_next() >> 16) % (MAX_FIRST + 1);
			// every fourth start on a line boundary
			if (i % 4 == 0) begin
				first = first - first % `EDGES_PER_LINE;
			end
			degree = int'(lcg_next() >> 16) % (MAX_DEGREE + 1);
			if (i % 13 == 6) begin
				degree = 0;
			end
			vertex_valid          <= 1'b1;
			vertex_job.id         <= lcg_next();
			vertex_job.first_edge <= 16'(first);
			vertex_job.degree     <= 16'(degree);
			do @(posedge clock); while (!vertex_ready);
			vertex_valid <= 1'b0;
		end
		repeat (3) @(posedge clock);
		while (!(vertex_ready && pending == 0 && !edge_available)) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
		$display("errors: %0d wrong values, %0d other checks, %0d assertions",
			value_errors, other_errors, UUT.u_asserts.failures);
		if (value_errors + other_errors + UUT.u_asserts.failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	//////////////////////////////
	// memory responder
	//////////////////////////////

	initial begin
		int        delay;
		mem_line_u line;
		forever begin
			@(posedge clock);
			if (rstn && read_valid) begin
				delay = int'(lcg_next() >> 29);
				for (int s = 0; s < `EDGES_PER_LINE; s++) begin
					line.raw[s * `EDGE_ID_BITS +: `EDGE_ID_BITS] = slot_value(read_addr, s);
				end
				repeat (delay) @(posedge clock);
				read_data_valid <= 1'b1;
				read_data       <= line;
				@(posedge clock);
				read_data_valid <= 1'b0;
			end
		end
	end

	// engine pops with occasional long stalls
	initial begin
		int          hold;
		logic [31:0] r;
		hold = 0;
		@(posedge rstn);
		forever begin
			@(posedge clock);
			r = lcg_next();
			if (hold > 0) begin
				hold--;
				edge_request <= 1'b0;
			end else if (r[31:25] == 7'd0) begin
				// FIFO fills up and reads wait for room
				hold = 24 + int'(r[14:10]);
				edge_request <= 1'b0;
			end else begin
				edge_request <= (r[25:18] < 8'd102);
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d expected items still outstanding",
				TIMEOUT_CYCLES, pending);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

/* verification/edge_job_checker.sv */
`include "edge_job_defines.svh"

module edge_job_checker
	import edge_job_pkg::*, edge_mem_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  vertex_valid,
	input  vertex_job_t           vertex_job,
	input  logic                  vertex_ready,
	input  logic [`ADDR_BITS-1:0] edge_base,
	input  logic                  read_valid,
	input  logic [`ADDR_BITS-1:0] read_addr,
	input  read_len_t             read_len,
	input  logic                  read_data_valid,
	input  mem_line_u             read_data,
	input  logic                  edge_request,
	input  logic                  edge_valid,
	input  edge_job_t             edge_job,
	input  logic                  edge_available,
	output int                    value_errors,
	output int                    other_errors,
	output int                    pending
);

	// predicted reads in order of issue
	logic [`ADDR_BITS-1:0]    exp_addr [$];
	int                       exp_len [$];
	int                       exp_slot [$];
	logic [`EDGE_ID_BITS-1:0] exp_src [$];
	int                       exp_seq [$];
	edge_job_t                exp_edges [$];

	// window of the read in flight
	int                       cur_len;
	int                       cur_slot;
	int                       cur_seq;
	logic [`EDGE_ID_BITS-1:0] cur_src;
	logic                     pop_seen;
	int                       n_value = 0;
	int                       n_other = 0;

	// FIFO fill and vertex progress as the timing rules predict them
	int                       push_left;
	int                       fifo_count;
	int                       vertex_left;
	logic                     zero_pending;
	logic                     ready_exp;

	assign value_errors = n_value;
	assign other_errors = n_other;

	task automatic expect_value(input string name, input logic [79:0] expected,
		input logic [79:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			n_value++;
		end
	endtask

	// split a vertex into line-limited reads
	task automatic plan_reads(input vertex_job_t v);
		int index;
		int left;
		int offset;
		int len;
		int seq;
		index = int'(v.first_edge);
		left  = int'(v.degree);
		seq   = 0;
		while (left > 0) begin
			offset = index * `EDGE_BYTES;
			len    = `EDGES_PER_LINE - (offset % `LINE_BYTES) / `EDGE_BYTES;
			if (left < len) begin
				len = left;
			end
			exp_addr.push_back(edge_base + 32'(offset - offset % `LINE_BYTES));
			exp_len.push_back(len);
			exp_slot.push_back((offset % `LINE_BYTES) / `EDGE_BYTES);
			exp_src.push_back(v.id);
			exp_seq.push_back(seq);
			index += len;
			left  -= len;
			seq   += len;
		end
	endtask

	always @(posedge clock) begin : compare
		edge_job_t want;
		logic      pop_now;
		logic      push_now;
		if (!rstn) begin
			cur_len      = 0;
			push_left    = 0;
			fifo_count   = 0;
			vertex_left  = 0;
			zero_pending = 1'b0;
			ready_exp    = 1'b1;
			pop_seen     <= 1'b0;
		end else begin
			expect_value("vertex_ready", 80'(ready_exp), 80'(vertex_ready));
			expect_value("edge_available", 80'(fifo_count != 0), 80'(edge_available));
			pop_now  = edge_request && (fifo_count != 0);
			push_now = (push_left > 0);
			// a degree 0 vertex is done after the plan cycle
			if (zero_pending) begin
				ready_exp    = 1'b1;
				zero_pending = 1'b0;
			end
			if (vertex_valid && vertex_ready) begin
				plan_reads(vertex_job);
				ready_exp    = 1'b0;
				vertex_left  = int'(vertex_job.degree);
				zero_pending = (vertex_job.degree == '0);
			end
			if (read_valid) begin
				if (exp_addr.size() == 0) begin
					$display("read issued while the model expects no read");
					n_other++;
					cur_len = 0;
				end else begin
					expect_value("read_addr", 80'(exp_addr[0]), 80'(read_addr));
					expect_value("read_len", 80'(exp_len[0]), 80'(read_len));
					if (fifo_count > `EDGE_FIFO_DEPTH - `EDGES_PER_LINE) begin
						$display("read issued while the FIFO had no room for a full line");
						n_other++;
					end
					void'(exp_addr.pop_front());
					cur_len  = exp_len.pop_front();
					cur_slot = exp_slot.pop_front();
					cur_src  = exp_src.pop_front();
					cur_seq  = exp_seq.pop_front();
				end
			end
			// one push per cycle after the data pulse
			if (push_now) begin
				fifo_count++;
				push_left--;
				vertex_left--;
				if (vertex_left == 0) begin
					ready_exp = 1'b1;
				end
			end
			if (pop_now) begin
				fifo_count--;
			end
			// slot s of a line is raw bits s*32 upward
			if (read_data_valid) begin
				push_left = cur_len;
				for (int s = 0; s < cur_len; s++) begin
					want.seq  = 16'(cur_seq + s);
					want.src  = cur_src;
					want.dest = read_data.raw[(cur_slot + s) * `EDGE_ID_BITS +: `EDGE_ID_BITS];
					exp_edges.push_back(want);
				end
			end
			expect_value("edge_valid", 80'(pop_seen), 80'(edge_valid));
			if (edge_valid) begin
				if (exp_edges.size() == 0) begin
					$display("edge_valid high while the model expects no edge");
					n_other++;
				end else begin
					want = exp_edges.pop_front();
					expect_value("edge_job", want, edge_job);
				end
			end
			pop_seen <= pop_now;
		end
		pending <= exp_addr.size() + exp_edges.size();
	end

endmodule

/* verification/edge_job_asserts.sv */
`include "edge_job_defines.svh"

module edge_job_asserts
	import edge_mem_pkg::*;
(
	input logic                  clock,
	input logic                  rstn,
	input logic                  read_valid,
	input logic                  read_data_valid,
	input logic [`ADDR_BITS-1:0] read_addr,
	input read_len_t             read_len,
	input logic                  push,
	input logic                  edge_request,
	input logic                  edge_available
);

	logic outstanding;
	int   occupancy;
	int   fail_overlap = 0;
	int   fail_len = 0;
	int   fail_align = 0;
	int   fail_full = 0;
	int   failures;

	assign failures = fail_overlap + fail_len + fail_align + fail_full;

	// mirror of the FIFO fill level
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= 1'b0;
			occupancy   <= 0;
		end else begin
			if (read_valid) begin
				outstanding <= 1'b1;
			end else if (read_data_valid) begin
				outstanding <= 1'b0;
			end
			occupancy <= occupancy + int'(push) - int'(edge_request && edge_available);
		end
	end

	one_read_in_flight: assert property (@(posedge clock) disable iff (!rstn)
		read_valid |-> !outstanding)
		else begin
			fail_overlap++;
			$error("read issued while another read is outstanding");
		end

	read_len_in_range: assert property (@(posedge clock) disable iff (!rstn)
		read_valid |-> (read_len != '0) && (read_len <= `EDGES_PER_LINE))
		else begin
			fail_len++;
			$error("read length outside one to one line of edges");
		end

	read_addr_aligned: assert property (@(posedge clock) disable iff (!rstn)
		read_valid |-> (read_addr[$clog2(`LINE_BYTES)-1:0] == '0))
		else begin
			fail_align++;
			$error("read address not on a line boundary");
		end

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (occupancy != `EDGE_FIFO_DEPTH))
		else begin
			fail_full++;
			$error("edge pushed into a full FIFO");
		end

endmodule

/* src/cu_edge_job_control.sv */
`include "edge_job_defines.svh"

module cu_edge_job_control
	import edge_job_pkg::*, edge_mem_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  vertex_valid,
	input  vertex_job_t           vertex_job,
	input  logic [`ADDR_BITS-1:0] edge_base,
	input  logic                  read_data_valid,
	input  mem_line_u             read_data,
	input  logic                  edge_request,
	output logic                  vertex_ready,
	output logic                  read_valid,
	output logic [`ADDR_BITS-1:0] read_addr,
	output read_len_t             read_len,
	output logic                  edge_valid,
	output edge_job_t             edge_job,
	output logic                  edge_available
);

	// sequencer to unpacker
	logic                     line_start;
	logic                     new_vertex;
	logic [`SLOT_BITS-1:0]    first_slot;
	read_len_t                slot_count;
	logic [`EDGE_ID_BITS-1:0] src_id;
	logic                     unpack_busy;

	// unpacker to FIFO and back
	logic      push;
	edge_job_t push_job;
	logic      line_room;

	edge_read_sequencer u_sequencer (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_valid   (vertex_valid),
		.vertex_job     (vertex_job),
		.edge_base      (edge_base),
		.read_data_valid(read_data_valid),
		.unpack_busy    (unpack_busy),
		.line_room      (line_room),
		.vertex_ready   (vertex_ready),
		.read_valid     (read_valid),
		.read_addr      (read_addr),
		.read_len       (read_len),
		.line_start     (line_start),
		.new_vertex     (new_vertex),
		.first_slot     (first_slot),
		.slot_count     (slot_count),
		.src_id         (src_id)
	);

	edge_line_unpacker u_unpacker (
		.clock      (clock),
		.rstn       (rstn),
		.line_start (line_start),
		.new_vertex (new_vertex),
		.read_data  (read_data),
		.first_slot (first_slot),
		.slot_count (slot_count),
		.src_id     (src_id),
		.unpack_busy(unpack_busy),
		.push       (push),
		.push_job   (push_job)
	);

	edge_job_fifo #(
		.DEPTH(`EDGE_FIFO_DEPTH)
	) u_fifo (
		.clock         (clock),
		.rstn          (rstn),
		.push          (push),
		.push_job      (push_job),
		.pop           (edge_request),
		.edge_valid    (edge_valid),
		.edge_job      (edge_job),
		.edge_available(edge_available),
		.line_room     (line_room)
	);

endmodule

/* src/edge_job_fifo.sv */
`include "edge_job_defines.svh"

module edge_job_fifo
	import edge_job_pkg::*;
#(
	parameter int DEPTH = `EDGE_FIFO_DEPTH
) (
	input  logic      clock,
	input  logic      rstn,
	input  logic      push,
	input  edge_job_t push_job,
	input  logic      pop,
	output logic      edge_valid,
	output edge_job_t edge_job,
	output logic      edge_available,
	output logic      line_room
);

	localparam int PTR_BITS = $clog2(DEPTH);
	// highest count that still leaves a full line free
	localparam logic [PTR_BITS:0] ROOM_LIMIT = (PTR_BITS + 1)'(DEPTH - `EDGES_PER_LINE);

	edge_job_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_pop;

	assign edge_available = (count != '0);
	assign line_room      = (count <= ROOM_LIMIT);
	// requests on an empty buffer are dropped
	assign do_pop         = pop && edge_available;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_job;
		end
		if (do_pop) begin
			edge_job <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			edge_valid <= 1'b0;
		end else begin
			edge_valid <= do_pop;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/edge_line_unpacker.sv */
`include "edge_job_defines.svh"

module edge_line_unpacker
	import edge_job_pkg::*, edge_mem_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     line_start,
	input  logic                     new_vertex,
	input  mem_line_u                read_data,
	input  logic [`SLOT_BITS-1:0]    first_slot,
	input  read_len_t                slot_count,
	input  logic [`EDGE_ID_BITS-1:0] src_id,
	output logic                     unpack_busy,
	output logic                     push,
	output edge_job_t                push_job
);

	// captured line and its slot window
	mem_line_u                line_q;
	logic [`SLOT_BITS-1:0]    slot_q;
	logic [`EDGE_ID_BITS-1:0] src_q;
	read_len_t                edges_left;

	// per-vertex edge number
	logic [`COUNT_BITS-1:0] seq_q;

	//////////////////////////////
	// line capture and walk
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (line_start) begin
			line_q <= read_data;
			slot_q <= first_slot;
			src_q  <= src_id;
		end else if (push) begin
			slot_q <= slot_q + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edges_left <= '0;
			seq_q      <= '0;
		end else begin
			if (line_start) begin
				edges_left <= slot_count;
				// numbering restarts for a new vertex only
				if (new_vertex) begin
					seq_q <= '0;
				end
			end else if (push) begin
				edges_left <= edges_left - 1'b1;
				seq_q      <= seq_q + 1'b1;
			end
		end
	end

	//////////////////////////////
	// edge job output
	//////////////////////////////

	assign push = (edges_left != '0);

	// drops on the cycle of the last push so the sequencer can move on
	assign unpack_busy = (edges_left > read_len_t'(1));

	always_comb begin
		push_job.seq  = seq_q;
		push_job.src  = src_q;
		push_job.dest = line_q.slot[slot_q];
	end

endmodule

/* src/edge_read_sequencer.sv */
`include "edge_job_defines.svh"

module edge_read_sequencer
	import edge_job_pkg::*, edge_mem_pkg::*;
(
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     vertex_valid,
	input  vertex_job_t              vertex_job,
	input  logic [`ADDR_BITS-1:0]    edge_base,
	input  logic                     read_data_valid,
	input  logic                     unpack_busy,
	input  logic                     line_room,
	output logic                     vertex_ready,
	output logic                     read_valid,
	output logic [`ADDR_BITS-1:0]    read_addr,
	output read_len_t                read_len,
	output logic                     line_start,
	output logic                     new_vertex,
	output logic [`SLOT_BITS-1:0]    first_slot,
	output read_len_t                slot_count,
	output logic [`EDGE_ID_BITS-1:0] src_id
);

	seq_state_e state;
	seq_state_e next_state;

	// running position in the inverse edge array
	logic [`COUNT_BITS-1:0] edge_index;
	logic [`COUNT_BITS-1:0] remaining;
	logic                   first_line;

	logic [`EDGE_ID_BITS-1:0] src_q;
	logic [`SLOT_BITS-1:0]    slot_q;

	logic [`ADDR_BITS-1:0] byte_offset;
	logic [`ADDR_BITS-1:0] line_offset;
	logic [`ADDR_BITS-1:0] line_base;
	logic [`SLOT_BITS-1:0] plan_slot;
	read_len_t             line_limit;
	read_len_t             plan_len;

	//////////////////////////////
	// read geometry
	//////////////////////////////

	always_comb begin
		byte_offset = `ADDR_BITS'(edge_index) * `EDGE_BYTES;
		line_offset = byte_offset % `LINE_BYTES;
		line_base   = byte_offset - line_offset;
		plan_slot   = `SLOT_BITS'(line_offset / `EDGE_BYTES);
		// a misaligned start stops at the line boundary
		line_limit  = read_len_t'(`EDGES_PER_LINE) - read_len_t'(plan_slot);
		plan_len    = (remaining < line_limit) ? remaining : line_limit;
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	assign vertex_ready = (state == seq_idle);
	// one read in flight and only when a whole line fits downstream
	assign read_valid   = (state == seq_issue) && line_room;
	assign line_start   = (state == seq_wait_data) && read_data_valid;

	always_comb begin
		next_state = state;
		case (state)
			seq_idle: begin
				if (vertex_valid) begin
					next_state = seq_plan;
				end
			end
			seq_plan: begin
				// degree 0 ends here
				if (remaining == '0) begin
					next_state = seq_idle;
				end else begin
					next_state = seq_issue;
				end
			end
			seq_issue: begin
				if (read_valid) begin
					next_state = seq_wait_data;
				end
			end
			seq_wait_data: begin
				if (read_data_valid) begin
					next_state = seq_unpack;
				end
			end
			seq_unpack: begin
				if (!unpack_busy) begin
					next_state = (remaining == '0) ? seq_idle : seq_plan;
				end
			end
			default: begin
				next_state = seq_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= seq_idle;
			edge_index <= '0;
			remaining  <= '0;
			first_line <= 1'b0;
		end else begin
			state <= next_state;
			if (vertex_valid && vertex_ready) begin
				edge_index <= vertex_job.first_edge;
				remaining  <= vertex_job.degree;
				first_line <= 1'b1;
			end
			// next read picks up at the following line boundary
			if (read_valid) begin
				edge_index <= edge_index + read_len;
				remaining  <= remaining - read_len;
			end
			if (line_start) begin
				first_line <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_valid && vertex_ready) begin
			src_q <= vertex_job.id;
		end
		if (state == seq_plan) begin
			read_addr <= edge_base + line_base;
			read_len  <= plan_len;
			slot_q    <= plan_slot;
		end
	end

	// slot window for the unpacker held until the data pulse
	assign first_slot = slot_q;
	assign slot_count = read_len;
	assign src_id     = src_q;
	assign new_vertex = first_line;

endmodule

/* src/edge_job_pkg.sv */
`include "edge_job_defines.svh"

package edge_job_pkg;

	//////////////////////////////
	// job side types
	//////////////////////////////

	// 64-bit vertex taken from the scheduler
	typedef struct packed {
		logic [`EDGE_ID_BITS-1:0] id;
		logic [`COUNT_BITS-1:0]   first_edge;
		logic [`COUNT_BITS-1:0]   degree;
	} vertex_job_t;

	// 80-bit edge handed to the engine
	typedef struct packed {
		logic [`COUNT_BITS-1:0]   seq;
		logic [`EDGE_ID_BITS-1:0] src;
		logic [`EDGE_ID_BITS-1:0] dest;
	} edge_job_t;

	typedef enum logic [2:0] {
		seq_idle,
		seq_plan,
		seq_issue,
		seq_wait_data,
		seq_unpack
	} seq_state_e;

endpackage

/* src/edge_mem_pkg.sv */
`include "edge_job_defines.svh"

package edge_mem_pkg;

	//////////////////////////////
	// memory side types
	//////////////////////////////

	localparam int LINE_BITS = `LINE_BYTES * 8;

	// edge count carried by one read command
	typedef logic [`COUNT_BITS-1:0] read_len_t;

	// one cacheline as delivered by the read port or as edge slots
	// slot 0 sits in the lowest EDGE_ID_BITS of the raw word
	typedef union packed {
		logic [LINE_BITS-1:0]                          raw;
		logic [`EDGES_PER_LINE-1:0][`EDGE_ID_BITS-1:0] slot;
	} mem_line_u;

endpackage

/* src/edge_job_defines.svh */
`ifndef EDGE_JOB_DEFINES_SVH
`define EDGE_JOB_DEFINES_SVH

//////////////////////////////
// ids and counters
//////////////////////////////

// vertex and edge id width
`define EDGE_ID_BITS 32

// in-degree, first edge index and per-line edge counts
`define COUNT_BITS 16

// byte address on the memory side
`define ADDR_BITS 32

//////////////////////////////
// line geometry
//////////////////////////////

`define EDGE_BYTES 4
`define LINE_BYTES 128

// LINE_BYTES / EDGE_BYTES entries, indexed by SLOT_BITS
`define EDGES_PER_LINE 32
`define SLOT_BITS 5

// default edge job FIFO size as a power of two of at least one line
`define EDGE_FIFO_DEPTH 64

`endif
